// ==== flist.f ====
rtl/doc_pkg.sv
rtl/doc_osc_if.sv
rtl/doc_regs.sv
rtl/doc_slot_timer.sv
rtl/doc_osc_engine.sv
rtl/doc_mixer.sv
rtl/doc5503.sv
verif/doc_chk.sv
verif/tb_doc5503.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert -Wno-fatal -j 0
TOP     := tb_doc5503
FLIST   := flist.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_doc5503.sv ====
// ------------------------------
// Directed testbench for doc5503
// Host register model, wave memory
// model and per-feature tests
// ------------------------------

`timescale 1ns/1ps

module tb_doc5503;
    import doc_pkg::*;

    localparam int TIMEOUT = 5000;   // clk_i cycles allowed per wait

    // Mix test table, oscillators 0 to 7
    localparam logic [7:0] MIX_BYTE [8] = '{8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF,
                                            8'h01, 8'h01, 8'h90};
    localparam logic [7:0] MIX_VOL  [8] = '{8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF,
                                            8'hFF, 8'hFF, 8'h40};
    localparam logic [3:0] MIX_CHAN [8] = '{4'd1, 4'd3, 4'd5, 4'd1, 4'd7,
                                            4'd0, 4'd2, 4'd4};

    logic        clk_i = 1'b0;
    logic        reset_n_i;
    logic        clk_en_i;
    logic        cs_n_i;
    logic        we_n_i;
    logic [7:0]  addr_i;
    logic [7:0]  data_i;
    logic [7:0]  data_o;
    logic        wave_rd_o;
    logic [15:0] wave_address_o;
    logic        wave_data_ready_i;
    logic [7:0]  wave_data_i;
    sample_t     mono_mix_o;
    sample_t     left_mix_o;
    sample_t     right_mix_o;
    logic        ready_o;

    logic [7:0]  wave_mem [65536];
    logic [15:0] fetch_q  [$];       // Every address the DUT fetched

    doc5503 UUT (.*);

    always #5 clk_i = ~clk_i;

    // clk_en_i on every fourth cycle
    initial begin : clk_enable
        int phase;
        clk_en_i = 1'b0;
        phase    = 0;
        forever begin
            @(negedge clk_i);
            phase    = (phase + 1) % 4;
            clk_en_i = (phase == 0);
        end
    end

    // Wave memory, answers each strobe after 1 to 3 cycles
    initial begin : wave_memory
        int unsigned delay;
        logic [15:0] addr;
        wave_data_ready_i = 1'b0;
        wave_data_i       = 8'h00;
        forever begin
            @(negedge clk_i);
            if (wave_rd_o) begin
                addr = wave_address_o;
                fetch_q.push_back(addr);
                delay = 1 + ($urandom % 3);
                repeat (delay) @(negedge clk_i);
                wave_data_ready_i = 1'b1;
                wave_data_i       = wave_mem[addr];
                @(negedge clk_i);
                wave_data_ready_i = 1'b0;
            end
        end
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mix(input string what, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", what, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [7:0] reg_addr(input reg_field_e f, input int osc);
        return {f, osc[4:0]};              // Bank in 7:5, oscillator in 4:0
    endfunction

    // Byte with top bit flipped as signed, times unsigned volume
    function automatic int sample_of(input logic [7:0] b, input logic [7:0] vol);
        return (int'(b) - 128) * int'(vol);
    endfunction

    function automatic sample_t sat_mix(input int sum);
        int scaled;
        scaled = sum >>> MIX_SHIFT;
        if (scaled > 32767) begin
            return 16'sh7FFF;
        end
        if (scaled < -32768) begin
            return sample_t'(-32768);
        end
        return sample_t'(scaled);
    endfunction

    task automatic apply_reset();
        @(negedge clk_i);
        reset_n_i = 1'b0;
        repeat (8) @(negedge clk_i);
        reset_n_i = 1'b1;
        fetch_q.delete();
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        cs_n_i = 1'b0;
        we_n_i = 1'b0;
        addr_i = addr;
        data_i = data;
        @(negedge clk_i);
        cs_n_i = 1'b1;
        we_n_i = 1'b1;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
        cs_n_i = 1'b0;
        we_n_i = 1'b1;
        addr_i = addr;
        @(negedge clk_i);
        cs_n_i = 1'b1;
        data   = data_o;                   // Registered on the edge just passed
    endtask

    // Slot timing is fixed, n slots of eight enable pulses
    task automatic settle_slots(input int n);
        int pulses;
        pulses = 0;
        while (pulses < n * CLKS_PER_SLOT) begin
            @(posedge clk_i);
            if (clk_en_i) pulses++;
        end
        @(negedge clk_i);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting for ready_o to rise");
                abort_run();
            end
        end
    endtask

    task automatic wait_fetches(input int n);
        int cycles;
        cycles = 0;
        while (fetch_q.size() < n) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting for wave fetch number %0d", n);
                abort_run();
            end
        end
    endtask

    task automatic wait_mixes(input sample_t m, input sample_t l, input sample_t r);
        int cycles;
        cycles = 0;
        while (!(mono_mix_o === m && left_mix_o === l && right_mix_o === r)) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Mixes did not reach the expected values in time");
                check_mix("mono_mix_o", mono_mix_o, m);
                check_mix("left_mix_o", left_mix_o, l);
                check_mix("right_mix_o", right_mix_o, r);
                abort_run();
            end
        end
    endtask

    // Expected sums of the enabled mix oscillators
    task automatic expect_mixes(input logic [7:0] on);
        int      mono;
        int      left;
        int      right;
        int      s;
        sample_t em;
        sample_t el;
        sample_t er;
        mono  = 0;
        left  = 0;
        right = 0;
        for (int i = 0; i < 8; i++) begin
            if (on[i]) begin
                s    = sample_of(MIX_BYTE[i], MIX_VOL[i]);
                mono = mono + s;
                if (MIX_CHAN[i][0]) left = left + s;    // Odd channel goes left
                else                right = right + s;
            end
        end
        em = sat_mix(mono);
        el = sat_mix(left);
        er = sat_mix(right);
        wait_mixes(em, el, er);
        settle_slots(18);                  // Two frames of 8 slots plus refresh
        check_mix("mono_mix_o", mono_mix_o, em);
        check_mix("left_mix_o", left_mix_o, el);
        check_mix("right_mix_o", right_mix_o, er);
    endtask

    task automatic register_access();
        logic [7:0] reg_exp [224];
        logic [7:0] en_val;
        logic [7:0] rd;
        for (int i = 0; i < NUM_OSC; i++) begin
            write_reg(reg_addr(CTRL, i), 8'h01);   // Hold all oscillators
        end
        for (int a = 0; a <= int'(REG_TOP); a++) begin
            reg_exp[a] = 8'($urandom);
            if (reg_field_e'(a[7:5]) == CTRL) reg_exp[a][0] = 1'b1;   // Stay halted
            write_reg(8'(a), reg_exp[a]);
        end
        en_val = 8'($urandom);
        write_reg(ADDR_OSC_EN, en_val);
        for (int a = 0; a <= int'(REG_TOP); a++) begin
            read_reg(8'(a), rd);
            check_byte($sformatf("data_o at 0x%02h", a), rd, reg_exp[a]);
        end
        read_reg(ADDR_OSC_EN, rd);
        check_byte("data_o at 0xe1", rd, en_val);
        read_reg(8'hE0, rd);
        check_byte("data_o at 0xe0", rd, 8'h00);
    endtask

    task automatic address_generation(input logic [7:0] wtp, input logic [7:0] rts,
                                      input logic [15:0] freq);
        int unsigned acc;
        int          shift;
        logic [15:0] exp;
        apply_reset();
        write_reg(reg_addr(CTRL, 0), 8'h01);
        settle_slots(2);
        write_reg(reg_addr(FL, 0), freq[7:0]);
        write_reg(reg_addr(FH, 0), freq[15:8]);
        write_reg(reg_addr(WTP, 0), wtp);
        write_reg(reg_addr(RTS, 0), rts);
        fetch_q.delete();
        write_reg(reg_addr(CTRL, 0), 8'h00);   // Free run from acc 0
        acc   = 0;
        shift = 9 + int'(rts[2:0]) - int'(rts[5:3]);
        for (int k = 0; k < 8; k++) begin
            wait_fetches(k + 1);
            exp = 16'(acc >> shift) | {wtp & ~((8'h01 << rts[5:3]) - 8'h01), 8'h00};
            check_addr("wave_address_o", fetch_q[k], exp);
            acc = (acc + freq) % (32'd1 << (17 + rts[2:0]));
        end
    endtask

    task automatic one_shot_halt();
        logic [7:0] rd;
        int         cycles;
        apply_reset();
        write_reg(reg_addr(CTRL, 0), 8'h01);
        settle_slots(2);
        write_reg(reg_addr(FH, 0), 8'h40);     // freq 0x4000, eighth step hits bit 17
        write_reg(reg_addr(WTP, 0), 8'h20);
        write_reg(reg_addr(VOL, 0), 8'h08);
        fetch_q.delete();
        write_reg(reg_addr(CTRL, 0), 8'h02);   // One-shot
        cycles = 0;
        rd     = 8'h00;
        while (!rd[0]) begin
            read_reg(reg_addr(CTRL, 0), rd);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting for the one-shot oscillator to halt");
                abort_run();
            end
        end
        check_byte("data_o control 0", rd, 8'h03);
        settle_slots(8);
        check_byte("fetch count", 8'(fetch_q.size()), 8'd8);
        for (int k = 0; k < 8; k++) begin
            check_addr("wave_address_o", fetch_q[k], 16'h2000 | 16'((k * 32'h4000) >> 9));
        end
    endtask

    task automatic mix_and_zero_halt();
        logic [7:0] rd;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            write_reg(reg_addr(CTRL, i), 8'h01);
        end
        settle_slots(2);
        write_reg(ADDR_OSC_EN, 8'h0E);           // Oscillators 0 to 7
        for (int i = 0; i < 8; i++) begin
            wave_mem[{8'h60 + 8'(i), 8'h00}] = MIX_BYTE[i];
            write_reg(reg_addr(WTP, i), 8'h60 + 8'(i));
            write_reg(reg_addr(VOL, i), MIX_VOL[i]);
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(reg_addr(CTRL, i), {MIX_CHAN[i], 4'h0});
        end
        expect_mixes(8'hFF);
        wave_mem[16'h6700] = 8'h00;              // Ends oscillator 7
        expect_mixes(8'h7F);
        read_reg(reg_addr(CTRL, 7), rd);
        check_byte("data_o control 7", rd, {MIX_CHAN[7], 4'h1});
        read_reg(reg_addr(WDS, 7), rd);
        check_byte("data_o wds 7", rd, 8'h00);
    endtask

    task automatic enable_count(input logic [7:0] en);
        int      last;
        sample_t exp;
        last = int'(en[5:1]);
        apply_reset();
        for (int i = 0; i < NUM_OSC; i++) begin
            wave_mem[{8'h40 + 8'(i), 8'h00}] = 8'h81;   // Sample +1 per oscillator
            write_reg(reg_addr(WTP, i), 8'h40 + 8'(i));
            write_reg(reg_addr(VOL, i), 8'h04);
        end
        write_reg(ADDR_OSC_EN, en);
        exp = sat_mix(sample_of(8'h81, 8'h04) * (last + 1));
        wait_mixes(exp, 16'sd0, exp);
        fetch_q.delete();
        settle_slots(3 * (last + 2));
        if (fetch_q.size() < 2 * (last + 1)) begin
            $display("Only %0d wave fetches over three frames", fetch_q.size());
            abort_run();
        end
        foreach (fetch_q[k]) begin
            if (fetch_q[k][15:8] > 8'h40 + 8'(last)) begin
                $display("Wave fetch at 0x%h from a disabled oscillator", fetch_q[k]);
                abort_run();
            end
        end
    endtask

    initial begin
        void'($urandom(43));
        reset_n_i = 1'b0;
        cs_n_i    = 1'b1;
        we_n_i    = 1'b1;
        addr_i    = 8'h00;
        data_i    = 8'h00;
        for (int a = 0; a < 65536; a++) begin
            wave_mem[a] = 8'(a ^ (a >> 8)) | 8'h01;   // Never zero
        end

        apply_reset();
        check_byte("ready_o", {7'd0, ready_o}, 8'h00);
        check_byte("wave_rd_o", {7'd0, wave_rd_o}, 8'h00);
        check_mix("mono_mix_o", mono_mix_o, 16'sd0);
        check_mix("left_mix_o", left_mix_o, 16'sd0);
        check_mix("right_mix_o", right_mix_o, 16'sd0);
        wait_ready();

        register_access();
        address_generation(8'hA5, 8'h13, 16'h1234);   // wts 2, res 3
        address_generation(8'h3C, 8'h00, 16'h0A00);
        address_generation(8'hFF, 8'h3F, 16'($urandom));
        one_shot_halt();
        mix_and_zero_halt();
        enable_count(8'h0A);
        enable_count(8'h1E);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verif/doc_chk.sv ====
// ------------------------------
// Protocol checks on doc5503
// Fetch strobe, ready, mix update
// ------------------------------

`timescale 1ns/1ps

module doc_chk (
    input logic             clk_i,
    input logic             reset_n_i,
    input logic             wave_rd_i,
    input logic             ready_i,
    input logic             frame_end_i,
    input doc_pkg::sample_t mono_mix_i,
    input doc_pkg::sample_t left_mix_i,
    input doc_pkg::sample_t right_mix_i
);
    logic [47:0] mixes_w;

    assign mixes_w = {mono_mix_i, left_mix_i, right_mix_i};

    rd_pulse_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        wave_rd_i |=> !wave_rd_i)                 // Single cycle fetch strobe
        else $error("wave_rd_o high on two consecutive cycles");

    ready_hold_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        ready_i |=> ready_i)
        else $error("ready_o fell after rising");

    // Latched only by the refresh slot
    mix_update_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !$stable(mixes_w) |-> $past(frame_end_i))
        else $error("Mix outputs changed outside a refresh");

endmodule

bind doc5503 doc_chk u_chk (
    .clk_i       (clk_i),
    .reset_n_i   (reset_n_i),
    .wave_rd_i   (wave_rd_o),
    .ready_i     (ready_o),
    .frame_end_i (frame_end_w),
    .mono_mix_i  (mono_mix_o),
    .left_mix_i  (left_mix_o),
    .right_mix_i (right_mix_o)
);

// ==== rtl/doc5503.sv ====
// ------------------------------
// DOC5503 style wavetable engine
// Top level wiring
// ------------------------------

`timescale 1ns/1ps

module doc5503 (
    input  logic             clk_i,
    input  logic             reset_n_i,
    input  logic             clk_en_i,
    input  logic             cs_n_i,
    input  logic             we_n_i,
    input  logic [7:0]       addr_i,
    input  logic [7:0]       data_i,
    output logic [7:0]       data_o,
    output logic             wave_rd_o,
    output logic [15:0]      wave_address_o,
    input  logic             wave_data_ready_i,
    input  logic [7:0]       wave_data_i,
    output doc_pkg::sample_t mono_mix_o,
    output doc_pkg::sample_t left_mix_o,
    output doc_pkg::sample_t right_mix_o,
    output logic             ready_o
);
    import doc_pkg::*;

    osc_idx_t   osc_last_w;
    logic       slot_start_w;
    osc_idx_t   slot_osc_w;
    logic       frame_end_w;
    logic       out_valid_w;
    sample_t    out_sample_w;
    logic [3:0] out_chan_w;

    doc_osc_if osc_bus ();

    doc_regs u_regs (
        .clk_i      (clk_i),
        .reset_n_i  (reset_n_i),
        .cs_n_i     (cs_n_i),
        .we_n_i     (we_n_i),
        .addr_i     (addr_i),
        .data_i     (data_i),
        .data_o     (data_o),
        .osc        (osc_bus.regs),
        .osc_last_o (osc_last_w)
    );

    doc_slot_timer u_slot_timer (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .clk_en_i     (clk_en_i),
        .osc_last_i   (osc_last_w),
        .slot_start_o (slot_start_w),
        .slot_osc_o   (slot_osc_w),
        .frame_end_o  (frame_end_w),
        .ready_o      (ready_o)
    );

    doc_osc_engine u_engine (
        .clk_i             (clk_i),
        .reset_n_i         (reset_n_i),
        .slot_start_i      (slot_start_w),
        .slot_osc_i        (slot_osc_w),
        .osc               (osc_bus.engine),
        .wave_rd_o         (wave_rd_o),
        .wave_address_o    (wave_address_o),
        .wave_data_ready_i (wave_data_ready_i),
        .wave_data_i       (wave_data_i),
        .out_valid_o       (out_valid_w),
        .out_sample_o      (out_sample_w),
        .out_chan_o        (out_chan_w)
    );

    doc_mixer u_mixer (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .out_valid_i  (out_valid_w),
        .out_sample_i (out_sample_w),
        .out_chan_i   (out_chan_w),
        .frame_end_i  (frame_end_w),
        .mono_mix_o   (mono_mix_o),
        .left_mix_o   (left_mix_o),
        .right_mix_o  (right_mix_o)
    );

endmodule

// ==== rtl/doc_mixer.sv ====
// ------------------------------
// Output mixer
// Mono, left and right sums,
// latched once per frame
// ------------------------------

`timescale 1ns/1ps

module doc_mixer (
    input  logic             clk_i,
    input  logic             reset_n_i,
    input  logic             out_valid_i,
    input  doc_pkg::sample_t out_sample_i,
    input  logic [3:0]       out_chan_i,
    input  logic             frame_end_i,
    output doc_pkg::sample_t mono_mix_o,
    output doc_pkg::sample_t left_mix_o,
    output doc_pkg::sample_t right_mix_o
);
    import doc_pkg::*;

    mix_sum_t mono_sum_r;
    mix_sum_t left_sum_r;
    mix_sum_t right_sum_r;
    mix_sum_t sample_ext_w;

    assign sample_ext_w = mix_sum_t'(out_sample_i);   // Sign extend

    // Scale down, then clamp to the 16 bit range
    function automatic sample_t scale_sat(input mix_sum_t sum);
        mix_sum_t shifted;
        shifted = sum >>> MIX_SHIFT;
        if (shifted > mix_sum_t'(32767))       return 16'sh7FFF;
        else if (shifted < mix_sum_t'(-32768)) return 16'sh8000;
        else                                   return shifted[15:0];
    endfunction

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            mono_sum_r  <= '0;
            left_sum_r  <= '0;
            right_sum_r <= '0;
            mono_mix_o  <= '0;
            left_mix_o  <= '0;
            right_mix_o <= '0;
        end else if (frame_end_i) begin
            mono_mix_o  <= scale_sat(mono_sum_r);
            left_mix_o  <= scale_sat(left_sum_r);
            right_mix_o <= scale_sat(right_sum_r);
            mono_sum_r  <= '0;
            left_sum_r  <= '0;
            right_sum_r <= '0;
        end else if (out_valid_i) begin
            mono_sum_r <= mono_sum_r + sample_ext_w;
            if (out_chan_i[0]) left_sum_r  <= left_sum_r + sample_ext_w;   // Odd channel
            else               right_sum_r <= right_sum_r + sample_ext_w;
        end
    end

endmodule

// ==== rtl/doc_osc_engine.sv ====
// ------------------------------
// Oscillator engine
// Fetch, scale, step and halt
// once per slot
// ------------------------------

`timescale 1ns/1ps

module doc_osc_engine (
    input  logic              clk_i,
    input  logic              reset_n_i,
    input  logic              slot_start_i,
    input  doc_pkg::osc_idx_t slot_osc_i,
    doc_osc_if.engine         osc,
    output logic              wave_rd_o,
    output logic [15:0]       wave_address_o,
    input  logic              wave_data_ready_i,
    input  logic [7:0]        wave_data_i,
    output logic              out_valid_o,
    output doc_pkg::sample_t  out_sample_o,
    output logic [3:0]        out_chan_o
);
    import doc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,        // wave_rd_o high
        S_WAIT_DATA,
        S_OUTPUT,       // Scale fetched byte
        S_STEP          // Advance accumulator
    } eng_state_e;

    eng_state_e state_r;
    osc_idx_t   idx_r;
    osc_regs_t  cur_r;            // Snapshot taken at slot start
    logic [7:0] data_r;

    logic [2:0]        wts_w;
    logic [2:0]        res_w;
    logic [4:0]        shift_w;
    logic [4:0]        top_bit_w;
    logic [7:0]        ptr_mask_w;
    logic [ACC_W:0]    sum_w;        // Extra bit keeps the carry
    logic [ACC_W:0]    acc_mask_w;
    logic              overflow_w;
    logic              fetch_done_w;
    logic              zero_byte_w;
    logic signed [7:0] data_s_w;
    logic signed [16:0] product_w;

    assign wts_w     = cur_r.rts[5:3];
    assign res_w     = cur_r.rts[2:0];
    assign shift_w   = 5'd9 + 5'(res_w) - 5'(wts_w);
    assign top_bit_w = 5'd17 + 5'(res_w);

    // Table pointer high byte, low wts bits give way to the phase
    assign ptr_mask_w     = 8'hFF << wts_w;
    assign wave_address_o = 16'(cur_r.acc >> shift_w) | {cur_r.wtp & ptr_mask_w, 8'h00};
    assign wave_rd_o      = (state_r == S_FETCH);

    assign sum_w      = cur_r.acc + cur_r.freq;
    assign acc_mask_w = ~({(ACC_W+1){1'b1}} << top_bit_w);
    assign overflow_w = sum_w[top_bit_w];

    assign fetch_done_w = (state_r == S_WAIT_DATA) && wave_data_ready_i;
    assign zero_byte_w  = (wave_data_i == 8'h00);

    // Offset binary byte to signed, times unsigned volume
    assign data_s_w  = signed'(data_r ^ 8'h80);
    assign product_w = data_s_w * signed'({1'b0, cur_r.vol});

    // Index follows the slot input until the snapshot is taken
    assign osc.idx       = (state_r == S_IDLE) ? slot_osc_i : idx_r;
    assign osc.wds_we    = fetch_done_w;
    assign osc.wds_wdata = wave_data_i;
    assign osc.acc_we    = (state_r == S_STEP);
    assign osc.acc_wdata = sum_w[ACC_W-1:0] & acc_mask_w[ACC_W-1:0];
    assign osc.halt_we   = (fetch_done_w && zero_byte_w) ||
                           ((state_r == S_STEP) && overflow_w && cur_r.ctrl[CTRL_ONESHOT]);

    assign out_chan_o = cur_r.ctrl[7:4];

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_r     <= S_IDLE;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    // Halted oscillators sit the slot out
                    if (slot_start_i && !osc.snap.ctrl[CTRL_HALT]) state_r <= S_FETCH;
                end
                S_FETCH: state_r <= S_WAIT_DATA;
                S_WAIT_DATA: begin
                    if (wave_data_ready_i) state_r <= zero_byte_w ? S_IDLE : S_OUTPUT;
                end
                S_OUTPUT: begin
                    out_valid_o <= 1'b1;
                    state_r     <= S_STEP;
                end
                S_STEP:  state_r <= S_IDLE;
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_r == S_IDLE) && slot_start_i) begin
            idx_r <= slot_osc_i;
            cur_r <= osc.snap;
        end
        if (fetch_done_w) data_r <= wave_data_i;
        if (state_r == S_OUTPUT) out_sample_o <= product_w[15:0];   // Fits, |x| <= 32640
    end

endmodule

// ==== rtl/doc_slot_timer.sv ====
// ------------------------------
// Slot timing generator
// Eight clk_en_i pulses per slot,
// one refresh slot per frame
// ------------------------------

`timescale 1ns/1ps

module doc_slot_timer (
    input  logic              clk_i,
    input  logic              reset_n_i,
    input  logic              clk_en_i,
    input  doc_pkg::osc_idx_t osc_last_i,
    output logic              slot_start_o,
    output doc_pkg::osc_idx_t slot_osc_o,
    output logic              frame_end_o,
    output logic              ready_o
);
    import doc_pkg::*;

    logic [$clog2(CLKS_PER_SLOT)-1:0] pulse_cnt_r;
    osc_idx_t osc_r;          // Oscillator of the next slot
    logic     refresh_r;      // Next slot is the refresh slot
    logic     ready_r;
    logic     tick_w;

    assign tick_w = clk_en_i && (pulse_cnt_r == CLKS_PER_SLOT - 1);

    assign slot_start_o = tick_w && !refresh_r;
    assign frame_end_o  = tick_w && refresh_r;
    assign slot_osc_o   = osc_r;
    assign ready_o      = ready_r || slot_start_o;   // High from the first slot on

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            pulse_cnt_r <= '0;
            osc_r       <= '0;
            refresh_r   <= 1'b0;
            ready_r     <= 1'b0;
        end else begin
            if (clk_en_i) begin
                pulse_cnt_r <= tick_w ? '0 : pulse_cnt_r + 1'b1;
            end
            if (slot_start_o) begin
                ready_r <= 1'b1;
                // >= also covers osc_en lowered mid frame
                if (osc_r >= osc_last_i) refresh_r <= 1'b1;
                else                     osc_r     <= osc_r + 1'b1;
            end
            if (frame_end_o) begin
                refresh_r <= 1'b0;
                osc_r     <= '0;
            end
        end
    end

endmodule

// ==== rtl/doc_regs.sv ====
// ------------------------------
// Oscillator register file
// Host port with registered read,
// engine port via doc_osc_if
// ------------------------------

`timescale 1ns/1ps

module doc_regs (
    input  logic              clk_i,
    input  logic              reset_n_i,
    input  logic              cs_n_i,
    input  logic              we_n_i,
    input  logic [7:0]        addr_i,
    input  logic [7:0]        data_i,
    output logic [7:0]        data_o,
    doc_osc_if.regs           osc,
    output doc_pkg::osc_idx_t osc_last_o
);
    import doc_pkg::*;

    logic [7:0]       fl_r   [NUM_OSC];
    logic [7:0]       fh_r   [NUM_OSC];
    logic [7:0]       vol_r  [NUM_OSC];
    logic [7:0]       wds_r  [NUM_OSC];
    logic [7:0]       wtp_r  [NUM_OSC];
    logic [7:0]       ctrl_r [NUM_OSC];
    logic [7:0]       rts_r  [NUM_OSC];
    logic [ACC_W-1:0] acc_r  [NUM_OSC];
    logic [7:0]       osc_en_r;

    reg_field_e field_w;
    osc_idx_t   host_osc_w;
    logic       host_wr_w;
    logic [7:0] rd_data_w;

    assign field_w    = reg_field_e'(addr_i[7:5]);
    assign host_osc_w = addr_i[OSC_IDX_W-1:0];
    assign host_wr_w  = !cs_n_i && !we_n_i;

    // Pairs enabled, bits 5:1 give the last oscillator
    assign osc_last_o = osc_en_r[5:1];

    assign osc.snap = '{
        freq: {fh_r[osc.idx], fl_r[osc.idx]},
        vol:  vol_r[osc.idx],
        wtp:  wtp_r[osc.idx],
        ctrl: ctrl_r[osc.idx],
        rts:  rts_r[osc.idx],
        acc:  acc_r[osc.idx]
    };

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < NUM_OSC; i++) begin
                fl_r[i]   <= '0;
                fh_r[i]   <= '0;
                vol_r[i]  <= '0;
                wds_r[i]  <= '0;
                wtp_r[i]  <= '0;
                ctrl_r[i] <= '0;   // Oscillators come up running
                rts_r[i]  <= '0;
                acc_r[i]  <= '0;
            end
            osc_en_r <= '0;
        end else begin
            // Engine side first so a host write below takes priority
            if (osc.acc_we)  acc_r[osc.idx] <= osc.acc_wdata;
            if (osc.wds_we)  wds_r[osc.idx] <= osc.wds_wdata;
            if (osc.halt_we) ctrl_r[osc.idx][CTRL_HALT] <= 1'b1;

            if (host_wr_w) begin
                if (addr_i == ADDR_OSC_EN) begin
                    osc_en_r <= data_i;
                end else if (addr_i <= REG_TOP) begin
                    case (field_w)
                        FL:      fl_r[host_osc_w]   <= data_i;
                        FH:      fh_r[host_osc_w]   <= data_i;
                        VOL:     vol_r[host_osc_w]  <= data_i;
                        WDS:     wds_r[host_osc_w]  <= data_i;
                        WTP:     wtp_r[host_osc_w]  <= data_i;
                        CTRL:    ctrl_r[host_osc_w] <= data_i;
                        RTS:     rts_r[host_osc_w]  <= data_i;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Read mux, unmapped addresses including E0 give 0
    always_comb begin
        rd_data_w = '0;
        if (addr_i == ADDR_OSC_EN) begin
            rd_data_w = osc_en_r;
        end else if (addr_i <= REG_TOP) begin
            case (field_w)
                FL:      rd_data_w = fl_r[host_osc_w];
                FH:      rd_data_w = fh_r[host_osc_w];
                VOL:     rd_data_w = vol_r[host_osc_w];
                WDS:     rd_data_w = wds_r[host_osc_w];
                WTP:     rd_data_w = wtp_r[host_osc_w];
                CTRL:    rd_data_w = ctrl_r[host_osc_w];
                RTS:     rd_data_w = rts_r[host_osc_w];
                default: rd_data_w = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!cs_n_i && we_n_i) data_o <= rd_data_w;   // Valid the cycle after
    end

endmodule

// ==== rtl/doc_osc_if.sv ====
// ------------------------------
// Register file to engine link
// Snapshot out, write strobes in
// ------------------------------

`timescale 1ns/1ps

interface doc_osc_if;
    import doc_pkg::*;

    osc_idx_t         idx;          // Oscillator being accessed
    osc_regs_t        snap;         // Combinational view of idx
    logic             acc_we;
    logic [ACC_W-1:0] acc_wdata;
    logic             wds_we;
    logic [7:0]       wds_wdata;
    logic             halt_we;      // Sets control bit 0 of idx

    modport regs (
        input  idx, acc_we, acc_wdata, wds_we, wds_wdata, halt_we,
        output snap
    );

    modport engine (
        output idx, acc_we, acc_wdata, wds_we, wds_wdata, halt_we,
        input  snap
    );

endinterface

// ==== rtl/doc_pkg.sv ====
// ------------------------------
// DOC wavetable engine package
// Sizes, address map, register
// field enum and oscillator types
// ------------------------------

package doc_pkg;

    localparam int NUM_OSC       = 32;     // Oscillators in the file
    localparam int OSC_IDX_W     = 5;
    localparam int CLKS_PER_SLOT = 8;      // clk_en_i pulses per slot
    localparam int ACC_W         = 24;     // Phase accumulator
    localparam int MIX_W         = 24;     // Headroom for 32 summed samples
    localparam int MIX_SHIFT     = 2;      // Applied before 16 bit saturation

    localparam logic [7:0] ADDR_OSC_EN = 8'hE1;
    localparam logic [7:0] REG_TOP     = 8'hDF;  // Last per-oscillator address

    // Control register bits, channel lives in 7:4
    localparam int CTRL_HALT    = 0;
    localparam int CTRL_ONESHOT = 1;

    typedef logic [OSC_IDX_W-1:0]  osc_idx_t;
    typedef logic signed [15:0]    sample_t;
    typedef logic signed [MIX_W-1:0] mix_sum_t;

    // Bank select, from host address bits 7:5
    typedef enum logic [2:0] {
        FL   = 3'd0,   // Frequency low
        FH   = 3'd1,   // Frequency high
        VOL  = 3'd2,
        WDS  = 3'd3,   // Last wave data sample
        WTP  = 3'd4,   // Wave table pointer
        CTRL = 3'd5,
        RTS  = 3'd6    // Table size 5:3, resolution 2:0
    } reg_field_e;

    // One oscillator's state as seen by the engine
    typedef struct packed {
        logic [15:0]      freq;
        logic [7:0]       vol;
        logic [7:0]       wtp;
        logic [7:0]       ctrl;
        logic [7:0]       rts;
        logic [ACC_W-1:0] acc;
    } osc_regs_t;

endpackage
